/* files.f */
logic/stb_pkg.sv
logic/stb_entry_ctrl.sv
logic/stb_entry_attr.sv
logic/stb_entry_data.sv
logic/stb_entry_hit.sv
logic/stb_entry_top.sv
verif/stb_entry_props.sv
verif/stb_entry_checker.sv
verif/stb_entry_tb.sv

/* logic/stb_entry_attr.sv */
// ======================================================================
// Store buffer entry attributes
// Address and attribute registers, bus request formatting
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module stb_entry_attr (
  input  logic                      stb_fsm_clk,
  input  logic                      create_en,
  input  stb_pkg::stb_create_t      create,
  input  logic                      dcache_wb,
  input  stb_pkg::data_t            entry_data,
  input  stb_pkg::bytes_t           entry_bytes,
  output stb_pkg::paddr_t           entry_pa,
  output stb_pkg::stb_entry_attr_t  entry_attr,
  output stb_pkg::stb_bus_req_t     bus_req
);
  import stb_pkg::*;

  logic             entry_ca;
  logic             entry_wo;
  logic             entry_buf;
  logic [DW_LSB-1:0] offset;

  // ====================================================================
  // Captured at create
  // ====================================================================
  always_ff @(posedge stb_fsm_clk) begin
    if (create_en) begin
      entry_pa             <= create.pa;
      entry_attr.attr      <= create.attr;
      entry_attr.wb        <= dcache_wb;
      entry_attr.lock      <= create.lock;
      entry_attr.size      <= create.size;
      entry_attr.priv_mode <= create.priv_mode;
      entry_attr.alct      <= create.alct;
    end
  end

  // ====================================================================
  // Bus request
  // ====================================================================
  assign entry_ca = entry_attr.attr[ATTR_CA];
  // Weakly ordered stores go out as a full doubleword
  assign entry_wo = !entry_attr.attr[ATTR_SO];

  // Cacheable stores take bufferable from the write-back mode
  assign entry_buf = entry_ca ? entry_attr.wb : entry_attr.attr[ATTR_BUF];

  assign offset = entry_wo ? '0 : entry_pa[DW_LSB-1:0];

  always_comb begin
    bus_req.pa        = {entry_pa[PADDR_W-1:DW_LSB], offset};
    bus_req.size      = entry_wo ? 3'b011 : {1'b0, entry_attr.size};
    bus_req.prot      = {2'b01, entry_attr.priv_mode[0]};
    bus_req.cache     = {entry_attr.alct, entry_ca, entry_wo, entry_buf};
    bus_req.user      = entry_attr.priv_mode[1];
    bus_req.data      = entry_data;
    bus_req.bytes_vld = entry_bytes;
  end

endmodule

`default_nettype wire

/* logic/stb_entry_ctrl.sv */
// ======================================================================
// Store buffer entry control
// Entry FSM, cache-hit flag, cache and bus requests, pop and merge enable
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module stb_entry_ctrl (
  input  logic                     stb_fsm_clk,
  input  logic                     cpurst_b,
  input  logic                     create_en,
  input  stb_pkg::stb_create_t     create,
  input  stb_pkg::stb_entry_attr_t entry_attr,
  input  logic                     wdata_ready,
  input  logic                     bytes_full,
  input  logic                     addr_hit,
  input  logic                     merge_finish,
  input  logic                     wca_grant,
  input  logic                     wbus_cmplt,
  output stb_pkg::stb_state_t      state,
  output logic                     entry_vld,
  output logic                     so_vld,
  output logic                     pop_vld,
  output logic                     dcache_req,
  output logic                     biu_req,
  output logic                     merge_en
);
  import stb_pkg::*;

  stb_state_t next_state;
  logic       cache_hit;
  logic       entry_so;

  // Where a store with its data in hand goes first
  function automatic stb_state_t issue_state(input logic hit, input logic ca,
                                             input logic lock);
    stb_state_t nxt;
    if (hit)
      nxt = STB_WCA;
    else if (ca && !lock)
      nxt = STB_MERGE;
    else
      nxt = STB_WBUS;
    return nxt;
  endfunction

  // ====================================================================
  // State register and cache-hit flag
  // ====================================================================
  always_ff @(posedge stb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b)
      state <= STB_IDLE;
    else
      state <= next_state;
  end

  always_ff @(posedge stb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b)
      cache_hit <= 1'b0;
    else if (create_en)
      cache_hit <= create.cache_hit;
  end

  always_comb begin
    next_state = state;
    case (state)
      STB_IDLE: begin
        if (create_en) begin
          if (create.src2_depd)
            next_state = STB_FWD;
          else
            next_state = issue_state(create.cache_hit, create.attr[ATTR_CA], create.lock);
        end
      end
      // Leave once the forwarded data is in
      STB_FWD: begin
        if (wdata_ready)
          next_state = issue_state(cache_hit, entry_attr.attr[ATTR_CA], entry_attr.lock);
      end
      STB_WCA: begin
        if (wca_grant)
          next_state = entry_attr.wb ? STB_IDLE : STB_WBUS;
      end
      STB_MERGE: begin
        if (merge_finish || bytes_full)
          next_state = STB_WBUS;
      end
      STB_WBUS: begin
        if (wbus_cmplt)
          next_state = STB_IDLE;
      end
      default: next_state = STB_IDLE;
    endcase
  end

  // ====================================================================
  // Outputs
  // ====================================================================
  assign entry_so   = entry_attr.attr[ATTR_SO];
  assign entry_vld  = (state != STB_IDLE);
  assign so_vld     = entry_vld && entry_so;
  assign dcache_req = (state == STB_WCA);
  assign biu_req    = (state == STB_WBUS);

  // Write-back cache write retires the store, write-through goes on to the bus
  assign pop_vld = (dcache_req && wca_grant && entry_attr.wb) ||
                   (biu_req && wbus_cmplt);

  // Only weakly ordered stores to the same doubleword fold in
  assign merge_en = (state == STB_MERGE) && !entry_so && addr_hit;

endmodule

`default_nettype wire

/* logic/stb_entry_data.sv */
// ======================================================================
// Store buffer entry data path
// Data and byte-valid registers, forward capture with byte rotate,
// byte merge of later stores to the same doubleword
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module stb_entry_data (
  input  logic                  stb_fsm_clk,
  input  logic                  cpurst_b,
  input  logic                  create_en,
  input  stb_pkg::stb_create_t  create,
  input  stb_pkg::stb_fwd_t     fwd,
  input  stb_pkg::stb_state_t   state,
  input  logic                  entry_vld,
  input  logic                  merge_en,
  input  logic                  merge_req,
  output stb_pkg::data_t        entry_data,
  output stb_pkg::bytes_t       entry_bytes,
  output logic                  src2_depd,
  output logic                  fwd_vld,
  output logic                  fwd_hit,
  output logic                  wdata_ready,
  output logic                  bytes_full
);
  import stb_pkg::*;

  reg_num_t            src2_reg;
  shift_t              shift;
  logic [2*DATA_W-1:0] fwd_dbl;
  data_t               fwd_rot;
  data_t               merge_data;
  logic                merge_vld;

  // ====================================================================
  // Forward match
  // ====================================================================
  always_ff @(posedge stb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b)
      src2_depd <= 1'b0;
    else if (create_en)
      src2_depd <= create.src2_depd;
    else if (fwd_hit)
      src2_depd <= 1'b0;
  end

  always_ff @(posedge stb_fsm_clk) begin
    if (create_en) begin
      src2_reg <= create.src2_reg;
      shift    <= create.shift;
    end
  end

  assign fwd_hit = src2_depd && (state == STB_FWD) && fwd.vld &&
                   (fwd.dest_reg == src2_reg);
  assign fwd_vld = fwd_hit && entry_vld;

  // Data is ready once no source is outstanding or it arrives now
  assign wdata_ready = !src2_depd || fwd_hit;

  // Rotate right by whole bytes
  assign fwd_dbl = {fwd.data, fwd.data} >> {shift, 3'b000};
  assign fwd_rot = fwd_dbl[DATA_W-1:0];

  // ====================================================================
  // Merge
  // ====================================================================
  assign merge_vld = merge_en && merge_req;

  always_comb begin
    for (int i = 0; i < BYTE_W; i++) begin
      merge_data[i*8 +: 8] = create.bytes_vld[i] ? create.data[i*8 +: 8]
                                                 : entry_data[i*8 +: 8];
    end
  end

  // Create wins, then forward, then merge
  always_ff @(posedge stb_fsm_clk) begin
    if (create_en) begin
      entry_data  <= create.data;
      entry_bytes <= create.bytes_vld;
    end else if (fwd_hit) begin
      entry_data  <= fwd_rot;
    end else if (merge_vld) begin
      entry_data  <= merge_data;
      entry_bytes <= entry_bytes | create.bytes_vld;
    end
  end

  assign bytes_full = &entry_bytes;

endmodule

`default_nettype wire

/* logic/stb_entry_hit.sv */
// ======================================================================
// Store buffer entry probe compare
// Line index, doubleword and byte overlap hits for a cache-pipeline probe
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module stb_entry_hit (
  input  stb_pkg::stb_probe_t probe,
  input  stb_pkg::paddr_t     entry_pa,
  input  stb_pkg::bytes_t     entry_bytes,
  input  logic                entry_vld,
  output stb_pkg::stb_hit_t   hit,
  output logic                addr_hit
);
  import stb_pkg::*;

  logic idx_eq;
  logic dw_eq;
  logic bytes_eq;
  logic bytes_ovlp;

  // Cache index and doubleword address
  assign idx_eq = (probe.pa[IDX_MSB-1:LINE_LSB] == entry_pa[IDX_MSB-1:LINE_LSB]);
  assign dw_eq  = (probe.pa[PADDR_W-1:DW_LSB] == entry_pa[PADDR_W-1:DW_LSB]);

  assign bytes_eq   = (probe.bytes_vld == entry_bytes);
  assign bytes_ovlp = |(probe.bytes_vld & entry_bytes);

  assign addr_hit = dw_eq && entry_vld;

  always_comb begin
    hit.idx      = idx_eq && entry_vld;
    hit.addr     = addr_hit;
    hit.addr_wca = addr_hit && bytes_ovlp;
    hit.full     = addr_hit && bytes_eq;
    // Overlap that does not cover the same bytes
    hit.part     = addr_hit && bytes_ovlp && !bytes_eq;
  end

endmodule

`default_nettype wire

/* logic/stb_entry_top.sv */
// ======================================================================
// Store buffer entry
// Captures one store, steers it to the data cache or the system bus,
// and answers probes from the cache pipeline
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module stb_entry_top (
  input  logic                  stb_fsm_clk,
  input  logic                  cpurst_b,
  input  logic                  create_en,
  input  stb_pkg::stb_create_t  create,
  input  logic                  dcache_wb,
  input  stb_pkg::stb_fwd_t     fwd,
  input  stb_pkg::stb_probe_t   probe,
  input  logic                  merge_req,
  input  logic                  merge_finish,
  input  logic                  wca_grant,
  input  logic                  wbus_cmplt,
  output logic                  entry_vld,
  output logic                  so_vld,
  output logic                  pop_vld,
  output logic                  dcache_req,
  output logic                  biu_req,
  output logic                  merge_en,
  output logic                  fwd_vld,
  output logic                  src2_depd,
  output stb_pkg::stb_hit_t     hit,
  output stb_pkg::stb_bus_req_t bus_req
);
  import stb_pkg::*;

  stb_state_t      state;
  stb_entry_attr_t entry_attr;
  paddr_t          entry_pa;
  data_t           entry_data;
  bytes_t          entry_bytes;
  logic            wdata_ready;
  logic            bytes_full;
  logic            addr_hit;

  stb_entry_ctrl u_ctrl (
    .stb_fsm_clk  (stb_fsm_clk),
    .cpurst_b     (cpurst_b),
    .create_en    (create_en),
    .create       (create),
    .entry_attr   (entry_attr),
    .wdata_ready  (wdata_ready),
    .bytes_full   (bytes_full),
    .addr_hit     (addr_hit),
    .merge_finish (merge_finish),
    .wca_grant    (wca_grant),
    .wbus_cmplt   (wbus_cmplt),
    .state        (state),
    .entry_vld    (entry_vld),
    .so_vld       (so_vld),
    .pop_vld      (pop_vld),
    .dcache_req   (dcache_req),
    .biu_req      (biu_req),
    .merge_en     (merge_en)
  );

  stb_entry_attr u_attr (
    .stb_fsm_clk (stb_fsm_clk),
    .create_en   (create_en),
    .create      (create),
    .dcache_wb   (dcache_wb),
    .entry_data  (entry_data),
    .entry_bytes (entry_bytes),
    .entry_pa    (entry_pa),
    .entry_attr  (entry_attr),
    .bus_req     (bus_req)
  );

  stb_entry_data u_data (
    .stb_fsm_clk (stb_fsm_clk),
    .cpurst_b    (cpurst_b),
    .create_en   (create_en),
    .create      (create),
    .fwd         (fwd),
    .state       (state),
    .entry_vld   (entry_vld),
    .merge_en    (merge_en),
    .merge_req   (merge_req),
    .entry_data  (entry_data),
    .entry_bytes (entry_bytes),
    .src2_depd   (src2_depd),
    .fwd_vld     (fwd_vld),
    .fwd_hit     (),
    .wdata_ready (wdata_ready),
    .bytes_full  (bytes_full)
  );

  stb_entry_hit u_hit (
    .probe       (probe),
    .entry_pa    (entry_pa),
    .entry_bytes (entry_bytes),
    .entry_vld   (entry_vld),
    .hit         (hit),
    .addr_hit    (addr_hit)
  );

endmodule

`default_nettype wire

/* logic/stb_pkg.sv */
// ======================================================================
// Store buffer entry package
// Widths, vector types, FSM encoding and the packed records that
// travel between the entry blocks
// ======================================================================
`default_nettype none

package stb_pkg;

  localparam int PADDR_W  = 40;
  localparam int DATA_W   = 64;
  localparam int BYTE_W   = 8;
  localparam int REG_W    = 5;
  localparam int LINE_LSB = 6;
  localparam int DW_LSB   = 3;
  localparam int IDX_MSB  = 12;

  // Positions inside the attribute field
  localparam int ATTR_CA  = 0;
  localparam int ATTR_SO  = 1;
  localparam int ATTR_BUF = 2;

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [BYTE_W-1:0]  bytes_t;
  typedef logic [REG_W-1:0]   reg_num_t;
  typedef logic [2:0]         shift_t;
  typedef logic [2:0]         attr_t;
  // Bit 1 user, bit 0 privileged
  typedef logic [1:0]         priv_t;

  // ====================================================================
  // Entry FSM encoding
  // ====================================================================
  typedef enum logic [3:0] {
    STB_IDLE  = 4'b0000,
    STB_WCA   = 4'b0010,
    STB_MERGE = 4'b0011,
    STB_WBUS  = 4'b0100,
    STB_FWD   = 4'b1000
  } stb_state_t;

  typedef struct packed {
    paddr_t     pa;
    attr_t      attr;
    logic [1:0] size;
    priv_t      priv_mode;
    logic       alct;
    logic       lock;
    logic       cache_hit;
    logic       src2_depd;
    reg_num_t   src2_reg;
    shift_t     shift;
    data_t      data;
    bytes_t     bytes_vld;
  } stb_create_t;

  typedef struct packed {
    logic     vld;
    reg_num_t dest_reg;
    data_t    data;
  } stb_fwd_t;

  typedef struct packed {
    paddr_t pa;
    bytes_t bytes_vld;
  } stb_probe_t;

  typedef struct packed {
    logic idx;
    logic addr;
    logic addr_wca;
    logic full;
    logic part;
  } stb_hit_t;

  typedef struct packed {
    attr_t      attr;
    logic       wb;
    logic       lock;
    logic [1:0] size;
    priv_t      priv_mode;
    logic       alct;
  } stb_entry_attr_t;

  // Bus write request
  typedef struct packed {
    paddr_t     pa;
    logic [2:0] size;
    logic [2:0] prot;
    logic [3:0] cache;
    logic       user;
    data_t      data;
    bytes_t     bytes_vld;
  } stb_bus_req_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the store buffer entry testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
  --top-module stb_entry_tb -o sim_stb_entry > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_stb_entry > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
else
  exit 1
fi

/* verif/stb_entry_checker.sv */
// ======================================================================
// Store buffer entry checker
// Compares the DUT ports with the expected values on the falling edge
// and counts the checks and the errors
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module stb_entry_checker (
  input  logic                  stb_fsm_clk,
  input  logic                  en,
  input  logic [7:0]            ctrl,
  input  logic [7:0]            exp_ctrl,
  input  stb_pkg::stb_hit_t     hit,
  input  stb_pkg::stb_hit_t     exp_hit,
  input  stb_pkg::stb_bus_req_t bus,
  input  stb_pkg::stb_bus_req_t exp_bus,
  input  logic                  bus_chk,
  output int                    errors,
  output int                    checks
);
  import stb_pkg::*;

  initial begin
    errors = 0;
    checks = 0;
  end

  // Bit order of the control vector, msb first
  function automatic string ctrl_name(input int i);
    string s;
    case (i)
      7: s = "entry_vld";
      6: s = "so_vld";
      5: s = "pop_vld";
      4: s = "dcache_req";
      3: s = "biu_req";
      2: s = "merge_en";
      1: s = "fwd_vld";
      default: s = "src2_depd";
    endcase
    return s;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail %s got %h expected %h at %0t ns", name, got, want, $time);
    end
  endtask

  // ====================================================================
  // Compare where all outputs are settled
  // ====================================================================
  always @(negedge stb_fsm_clk) begin
    if (en) begin
      for (int i = 0; i < 8; i++)
        check_val(ctrl_name(i), 64'(ctrl[i]), 64'(exp_ctrl[i]));
      check_val("hit.idx", 64'(hit.idx), 64'(exp_hit.idx));
      check_val("hit.addr", 64'(hit.addr), 64'(exp_hit.addr));
      check_val("hit.addr_wca", 64'(hit.addr_wca), 64'(exp_hit.addr_wca));
      check_val("hit.full", 64'(hit.full), 64'(exp_hit.full));
      check_val("hit.part", 64'(hit.part), 64'(exp_hit.part));
      // Bus fields only mean something while a store is held
      if (bus_chk) begin
        check_val("bus_req.pa", 64'(bus.pa), 64'(exp_bus.pa));
        check_val("bus_req.size", 64'(bus.size), 64'(exp_bus.size));
        check_val("bus_req.prot", 64'(bus.prot), 64'(exp_bus.prot));
        check_val("bus_req.cache", 64'(bus.cache), 64'(exp_bus.cache));
        check_val("bus_req.user", 64'(bus.user), 64'(exp_bus.user));
        check_val("bus_req.data", bus.data, exp_bus.data);
        check_val("bus_req.bytes_vld", 64'(bus.bytes_vld), 64'(exp_bus.bytes_vld));
      end
    end
  end

endmodule

`default_nettype wire

/* verif/stb_entry_props.sv */
// ======================================================================
// Store buffer entry control assertions
// Request hand-over and pop ordering, bound into the control block
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module stb_entry_props (
  input logic stb_fsm_clk,
  input logic cpurst_b,
  input logic dcache_req,
  input logic biu_req,
  input logic wca_grant,
  input logic pop_vld,
  input logic entry_vld
);

  int fails = 0;

  // The bus request follows a cache request only through a grant
  req_excl_a: assert property (@(posedge stb_fsm_clk) disable iff (!cpurst_b)
    dcache_req |=> !biu_req || $past(wca_grant))
    else begin
      $error("biu_req followed dcache_req without wca_grant");
      fails++;
    end

  // A pop retires a valid entry
  pop_in_vld_a: assert property (@(posedge stb_fsm_clk) disable iff (!cpurst_b)
    pop_vld |=> $fell(entry_vld))
    else begin
      $error("pop_vld did not retire a valid entry");
      fails++;
    end

  // The entry only empties through a pop
  fall_after_pop_a: assert property (@(posedge stb_fsm_clk) disable iff (!cpurst_b)
    $fell(entry_vld) |-> $past(pop_vld))
    else begin
      $error("entry_vld fell without pop_vld");
      fails++;
    end

endmodule

`default_nettype wire

/* verif/stb_entry_tb.sv */
// ======================================================================
// Store buffer entry testbench
// Random stores through the bus, cache, forward and merge paths,
// a cycle model of the entry and random probes against it
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module stb_entry_tb;
  import stb_pkg::*;

  localparam int NUM_TESTS = 6;
  localparam int CLK_HALF  = 10;

  typedef struct packed {
    stb_state_t  st;
    logic        wb;
    stb_create_t c;
  } model_t;

  typedef struct packed {
    logic [7:0]   ctrl;
    stb_hit_t     hit;
    stb_bus_req_t bus;
  } expect_t;

  logic         stb_fsm_clk;
  logic         cpurst_b;
  logic         create_en;
  stb_create_t  create;
  logic         dcache_wb;
  stb_fwd_t     fwd;
  stb_probe_t   probe;
  logic         merge_req;
  logic         merge_finish;
  logic         wca_grant;
  logic         wbus_cmplt;
  logic         entry_vld;
  logic         so_vld;
  logic         pop_vld;
  logic         dcache_req;
  logic         biu_req;
  logic         merge_en;
  logic         fwd_vld;
  logic         src2_depd;
  stb_hit_t     hit;
  stb_bus_req_t bus_req;

  model_t  m;
  expect_t exp_v;
  int      errors;
  int      checks;
  int      seed_val;

  initial stb_fsm_clk = 1'b0;
  always #CLK_HALF stb_fsm_clk = ~stb_fsm_clk;

  stb_entry_top u_stb_entry_top (.*);

  stb_entry_checker u_checker (
    .stb_fsm_clk (stb_fsm_clk),
    .en          (cpurst_b),
    .ctrl        ({entry_vld, so_vld, pop_vld, dcache_req, biu_req, merge_en,
                   fwd_vld, src2_depd}),
    .exp_ctrl    (exp_v.ctrl),
    .hit         (hit),
    .exp_hit     (exp_v.hit),
    .bus         (bus_req),
    .exp_bus     (exp_v.bus),
    .bus_chk     (exp_v.ctrl[7]),
    .errors      (errors),
    .checks      (checks)
  );

  bind stb_entry_ctrl stb_entry_props u_props (
    .stb_fsm_clk (stb_fsm_clk),
    .cpurst_b    (cpurst_b),
    .dcache_req  (dcache_req),
    .biu_req     (biu_req),
    .wca_grant   (wca_grant),
    .pop_vld     (pop_vld),
    .entry_vld   (entry_vld)
  );

  // ====================================================================
  // Reference model
  // ====================================================================
  // Byte i of the result is byte i+sh of the source
  function automatic data_t rot_bytes(input data_t d, input shift_t sh);
    data_t r;
    for (int i = 0; i < 8; i++)
      r[i*8 +: 8] = d[((i + int'(sh)) % 8)*8 +: 8];
    return r;
  endfunction

  function automatic stb_state_t first_target(input logic chit, input logic ca,
                                              input logic lock);
    stb_state_t s;
    if (chit)
      s = STB_WCA;
    else if (ca && !lock)
      s = STB_MERGE;
    else
      s = STB_WBUS;
    return s;
  endfunction

  function automatic logic fwd_match(input model_t md, input stb_fwd_t f);
    return md.c.src2_depd && (md.st == STB_FWD) && f.vld &&
           (f.dest_reg == md.c.src2_reg);
  endfunction

  function automatic logic dw_match(input model_t md, input stb_probe_t p);
    return (md.st != STB_IDLE) && (p.pa[39:3] == md.c.pa[39:3]);
  endfunction

  function automatic model_t model_step(input model_t md, input logic ce,
                                        input stb_create_t c, input logic wb,
                                        input stb_fwd_t f, input stb_probe_t p,
                                        input logic mreq, input logic mfin,
                                        input logic gnt, input logic cmpl);
    model_t n;
    logic   fh;
    n  = md;
    fh = fwd_match(md, f);
    if (ce) begin
      n.c  = c;
      n.wb = wb;
    end else if (fh) begin
      n.c.data      = rot_bytes(f.data, md.c.shift);
      n.c.src2_depd = 1'b0;
    end else if (mreq && dw_match(md, p) && md.st == STB_MERGE && !md.c.attr[ATTR_SO]) begin
      for (int i = 0; i < 8; i++)
        if (c.bytes_vld[i])
          n.c.data[i*8 +: 8] = c.data[i*8 +: 8];
      n.c.bytes_vld = md.c.bytes_vld | c.bytes_vld;
    end
    case (md.st)
      STB_IDLE:
        if (ce)
          n.st = c.src2_depd ? STB_FWD : first_target(c.cache_hit, c.attr[ATTR_CA], c.lock);
      STB_FWD:
        if (fh)
          n.st = first_target(md.c.cache_hit, md.c.attr[ATTR_CA], md.c.lock);
      STB_WCA:
        if (gnt)
          n.st = md.wb ? STB_IDLE : STB_WBUS;
      STB_MERGE:
        if (mfin || &md.c.bytes_vld)
          n.st = STB_WBUS;
      STB_WBUS:
        if (cmpl)
          n.st = STB_IDLE;
      default: n.st = STB_IDLE;
    endcase
    return n;
  endfunction

  // Expected outputs of the entry held in the model
  function automatic expect_t ref_entry(input model_t md, input stb_fwd_t f,
                                        input stb_probe_t p, input logic gnt,
                                        input logic cmpl);
    expect_t e;
    logic    vld;
    logic    so;
    logic    ca;
    logic    ah;
    logic    ovl;
    logic    eq;
    logic    pop;
    vld = (md.st != STB_IDLE);
    so  = md.c.attr[ATTR_SO];
    ca  = md.c.attr[ATTR_CA];
    ah  = dw_match(md, p);
    ovl = |(p.bytes_vld & md.c.bytes_vld);
    eq  = (p.bytes_vld == md.c.bytes_vld);
    pop = (md.st == STB_WCA && gnt && md.wb) || (md.st == STB_WBUS && cmpl);
    e.ctrl = {vld, vld && so, pop, md.st == STB_WCA, md.st == STB_WBUS,
              md.st == STB_MERGE && !so && ah, fwd_match(md, f) && vld, md.c.src2_depd};
    e.hit.idx      = vld && (p.pa[11:6] == md.c.pa[11:6]);
    e.hit.addr     = ah;
    e.hit.addr_wca = ah && ovl;
    e.hit.full     = ah && eq;
    e.hit.part     = ah && ovl && !eq;
    e.bus.pa        = so ? md.c.pa : {md.c.pa[39:3], 3'b000};
    e.bus.size      = so ? {1'b0, md.c.size} : 3'd3;
    e.bus.prot      = {2'b01, md.c.priv_mode[0]};
    e.bus.cache     = {md.c.alct, ca, !so, ca ? md.wb : md.c.attr[ATTR_BUF]};
    e.bus.user      = md.c.priv_mode[1];
    e.bus.data      = md.c.data;
    e.bus.bytes_vld = md.c.bytes_vld;
    return e;
  endfunction

  always @(posedge stb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      m.st          <= STB_IDLE;
      m.c.src2_depd <= 1'b0;
      m.c.cache_hit <= 1'b0;
    end else begin
      m <= model_step(m, create_en, create, dcache_wb, fwd, probe, merge_req,
                      merge_finish, wca_grant, wbus_cmplt);
    end
  end

  always_comb exp_v = ref_entry(m, fwd, probe, wca_grant, wbus_cmplt);

  // ====================================================================
  // Stimulus helpers
  // ====================================================================
  function automatic stb_create_t rand_create();
    stb_create_t c;
    c.pa        = {8'($urandom()), $urandom()};
    c.attr      = 3'($urandom());
    c.size      = 2'($urandom());
    c.priv_mode = 2'($urandom());
    c.alct      = 1'($urandom());
    c.lock      = 1'($urandom());
    c.cache_hit = 1'($urandom());
    c.src2_depd = 1'($urandom());
    c.src2_reg  = 5'($urandom());
    c.shift     = 3'($urandom());
    c.data      = {$urandom(), $urandom()};
    c.bytes_vld = 8'($urandom());
    return c;
  endfunction

  task automatic start_store(input stb_create_t c, input logic wb);
    @(posedge stb_fsm_clk);
    create_en <= 1'b1;
    create    <= c;
    dcache_wb <= wb;
    @(posedge stb_fsm_clk);
    create_en <= 1'b0;
  endtask

  // Pulse wca_grant on 0 and wbus_cmplt on 1 and merge_finish on anything else
  task automatic pulse(input int sel);
    @(posedge stb_fsm_clk);
    case (sel)
      0: wca_grant <= 1'b1;
      1: wbus_cmplt <= 1'b1;
      default: merge_finish <= 1'b1;
    endcase
    @(posedge stb_fsm_clk);
    wca_grant    <= 1'b0;
    wbus_cmplt   <= 1'b0;
    merge_finish <= 1'b0;
  endtask

  // Answer whatever the entry asks for until it empties
  task automatic drain();
    forever begin
      @(negedge stb_fsm_clk);
      if (!entry_vld)
        break;
      if (dcache_req)
        pulse(0);
      else if (biu_req)
        pulse(1);
      else if (!src2_depd)
        pulse(2);
    end
  endtask

  // ====================================================================
  // Tests
  // ====================================================================
  initial begin
    stb_create_t c;
    stb_create_t mc;
    stb_probe_t  pb;
    stb_fwd_t    f;
    int unsigned sel;
    seed_val = $urandom(32'hfc4a);
    cpurst_b     <= 1'b0;
    create_en    <= 1'b0;
    create       <= '0;
    dcache_wb    <= 1'b0;
    fwd          <= '0;
    probe        <= '0;
    merge_req    <= 1'b0;
    merge_finish <= 1'b0;
    wca_grant    <= 1'b0;
    wbus_cmplt   <= 1'b0;
    repeat (16) @(posedge stb_fsm_clk);
    cpurst_b <= 1'b1;
    // Idle outputs after reset
    repeat (4) @(posedge stb_fsm_clk);

    // Non-cacheable or locked stores go straight to the bus
    repeat (8) begin
      c = rand_create();
      c.cache_hit = 1'b0;
      c.src2_depd = 1'b0;
      if (c.attr[ATTR_CA])
        c.lock = 1'b1;
      start_store(c, 1'($urandom()));
      drain();
    end

    // Cache hits pop on the grant when write-back
    repeat (8) begin
      c = rand_create();
      c.cache_hit = 1'b1;
      c.src2_depd = 1'b0;
      start_store(c, 1'($urandom()));
      drain();
    end

    // Dependent stores get a wrong register first
    repeat (4) begin
      c = rand_create();
      c.src2_depd = 1'b1;
      start_store(c, 1'($urandom()));
      repeat (2) @(posedge stb_fsm_clk);
      f.vld      = 1'b1;
      f.dest_reg = c.src2_reg ^ 5'h1;
      f.data     = {$urandom(), $urandom()};
      fwd <= f;
      @(posedge stb_fsm_clk);
      f.dest_reg = c.src2_reg;
      f.data     = {$urandom(), $urandom()};
      fwd <= f;
      @(posedge stb_fsm_clk);
      fwd <= '0;
      drain();
    end

    // Merging later stores into a cacheable entry
    // The last entry is strongly ordered and must not merge
    for (int k = 0; k < 4; k++) begin
      c = rand_create();
      c.attr[ATTR_CA] = 1'b1;
      c.attr[ATTR_SO] = (k == 3);
      c.lock          = 1'b0;
      c.cache_hit     = 1'b0;
      c.src2_depd     = 1'b0;
      start_store(c, 1'($urandom()));
      repeat (6) begin
        @(posedge stb_fsm_clk);
        pb.pa        = ($urandom() % 4 == 0) ? {8'($urandom()), $urandom()}
                                             : {c.pa[39:3], 3'($urandom())};
        pb.bytes_vld = 8'($urandom());
        mc           = c;
        mc.data      = {$urandom(), $urandom()};
        mc.bytes_vld = 8'($urandom()) & 8'($urandom());
        probe     <= pb;
        create    <= mc;
        merge_req <= 1'b1;
      end
      @(posedge stb_fsm_clk);
      merge_req <= 1'b0;
      drain();
    end

    // Random probes against a store waiting on the bus
    c = rand_create();
    c.attr[ATTR_CA] = 1'b0;
    c.cache_hit     = 1'b0;
    c.src2_depd     = 1'b0;
    start_store(c, 1'b0);
    repeat (24) begin
      @(posedge stb_fsm_clk);
      sel = $urandom() % 3;
      if (sel == 0)
        pb.pa = {c.pa[39:3], 3'($urandom())};
      else if (sel == 1)
        pb.pa = {28'($urandom()), c.pa[11:0]};
      else
        pb.pa = {8'($urandom()), $urandom()};
      pb.bytes_vld = ($urandom() % 2 == 0) ? c.bytes_vld : 8'($urandom());
      probe <= pb;
    end
    drain();

    repeat (4) @(posedge stb_fsm_clk);
    $display("checks %0d errors %0d assertion failures %0d", checks, errors,
             u_stb_entry_top.u_ctrl.u_props.fails);
    if (errors == 0 && u_stb_entry_top.u_ctrl.u_props.fails == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // Watchdog allows 200 cycles for each test plus reset
  initial begin
    #((NUM_TESTS * 200 + 16) * 2 * CLK_HALF);
    $display("Timeout, the DUT did not finish the tests in time");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire
